// ==== Makefile ====
# Verilator build and run for the mac8 testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mac8_tb
FILELIST  := mac8.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mac8.f ====
rtl/mac8_pkg.sv
rtl/cla_adder.sv
rtl/array_multiplier.sv
rtl/mac_config.sv
rtl/mac_datapath.sv
rtl/mac8_top.sv
verif/mac8_tb.sv

// ==== rtl/array_multiplier.sv ====
`timescale 1ns/1ps

// Unsigned 8x8 array multiplier.
// Partial products are reduced by nine small CLA groups and a row of
// full adders, then the last two rows meet in a 13-bit CLA.
module array_multiplier
    import mac8_pkg::*;
(
    input  logic [OP_W-1:0]   a,
    input  logic [OP_W-1:0]   b,
    output logic [PROD_W-1:0] product
);
    logic [OP_W-1:0] pp [OP_W];     // Row i holds b gated by a[i], weight i.

    // Group sums, bit 0 is the lowest weight of each group.
    logic [3:0] s1;                 // Weights 6..9.
    logic [3:0] s2;                 // Weights 5..8.
    logic [3:0] s3;                 // Weights 7..10.
    logic [3:0] s4;                 // Weights 3..6.
    logic [3:0] s5;                 // Weights 7..10.
    logic [1:0] s6;                 // Weights 11..12.
    logic [3:0] s7;                 // Weights 4..7.
    logic [3:0] s8;                 // Weights 8..11.
    logic [3:0] s9;                 // Weights 10..13.
    logic       c1;                 // Group carries.
    logic       c2;
    logic       c3;
    logic       c4;
    logic       c5;
    logic       c6;
    logic       c7;
    logic       c8;
    logic       c9;

    // Half and full adder outputs, weights 2..9 for sums.
    logic s_b, s_c, s_d, s_e, s_f, s_g, s_h, s_i;
    logic c_a, c_b, c_c, c_d, c_e, c_f, c_g, c_h, c_i;

    // Full adder as plain logic, returns {carry, sum}.
    function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
        full_add = {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    for (genvar i = 0; i < OP_W; i++) begin : g_pp
        assign pp[i] = a[i] ? b : '0;
    end

    assign product[0] = pp[0][0];   // Only one bit of weight 0.

    // First level: four groups straight from the partial products.
    cla_adder #(.WIDTH(4)) cla1_i (
        .in1 ({pp[2][4], pp[2][5], pp[2][6], pp[2][7]}),
        .in2 ({pp[3][3], pp[3][4], pp[3][5], pp[3][6]}),
        .cin (1'b0), .sum (s1), .cout (c1)
    );
    cla_adder #(.WIDTH(4)) cla2_i (
        .in1 ({pp[4][1], pp[4][2], pp[4][3], pp[4][4]}),
        .in2 ({pp[5][0], pp[5][1], pp[5][2], pp[5][3]}),
        .cin (1'b0), .sum (s2), .cout (c2)
    );
    cla_adder #(.WIDTH(4)) cla3_i (
        .in1 ({pp[6][1], pp[6][2], pp[6][3], pp[6][4]}),
        .in2 ({pp[7][0], pp[7][1], pp[7][2], pp[7][3]}),
        .cin (1'b0), .sum (s3), .cout (c3)
    );
    cla_adder #(.WIDTH(4)) cla4_i (
        .in1 ({pp[0][3], pp[0][4], pp[0][5], pp[0][6]}),
        .in2 ({pp[1][2], pp[1][3], pp[1][4], pp[1][5]}),
        .cin (1'b0), .sum (s4), .cout (c4)
    );

    // Second level mixes raw bits with first-level sums.
    cla_adder #(.WIDTH(4)) cla5_i (
        .in1 ({pp[0][7], pp[1][7], pp[4][5], pp[3][7]}),
        .in2 ({pp[1][6], s1[2], pp[5][4], pp[4][6]}),
        .cin (s3[0]), .sum (s5), .cout (c5)     // s3[0] has weight 7.
    );
    cla_adder #(.WIDTH(2)) cla6_i (
        .in1 ({pp[4][7], pp[5][7]}),
        .in2 ({pp[5][6], pp[6][6]}),
        .cin (pp[6][5]), .sum (s6), .cout (c6)
    );
    cla_adder #(.WIDTH(4)) cla7_i (
        .in1 ({pp[2][2], pp[2][3], pp[6][0], s1[1]}),
        .in2 ({pp[3][1], pp[3][2], s1[0], s2[2]}),
        .cin (1'b0), .sum (s7), .cout (c7)
    );
    cla_adder #(.WIDTH(4)) cla8_i (
        .in1 ({s2[3], s1[3], pp[5][5], c3}),
        .in2 ({s3[1], c2, c1, pp[7][4]}),
        .cin (1'b0), .sum (s8), .cout (c8)
    );
    cla_adder #(.WIDTH(4)) cla9_i (
        .in1 ({s3[3], c5, pp[7][5], pp[6][7]}),
        .in2 ({s5[3], s6[0], s6[1], pp[7][6]}),
        .cin (s8[2]), .sum (s9), .cout (c9)     // s8[2] has weight 10.
    );

    // Low columns, one adder per weight from 1 up to 9.
    assign product[1]   = pp[0][1] ^ pp[1][0];
    assign c_a          = pp[0][1] & pp[1][0];
    assign {c_b, s_b}   = full_add(pp[0][2], pp[1][1], pp[2][0]);
    assign {c_c, s_c}   = full_add(pp[2][1], pp[3][0], s4[0]);
    assign {c_d, s_d}   = full_add(pp[4][0], s4[1], s7[0]);
    assign {c_e, s_e}   = full_add(s2[0], s4[2], s7[1]);
    assign {c_f, s_f}   = full_add(s2[1], s4[3], s7[2]);
    assign {c_g, s_g}   = full_add(c4, s5[0], s7[3]);
    assign {c_h, s_h}   = full_add(s5[1], c7, s8[0]);
    assign {c_i, s_i}   = full_add(s3[2], s5[2], s8[1]);

    // Final two rows, weights 2..14, carry out is bit 15.
    cla_adder #(.WIDTH(13)) cla_final_i (
        .in1 ({s_b, s_c, s_d, s_e, s_f, s_g, s_h, s_i, s9[0], s9[1], s9[2], s9[3], pp[7][7]}),
        .in2 ({c_a, c_b, c_c, c_d, c_e, c_f, c_g, c_h, c_i, s8[3], c8, c6, c9}),
        .cin (1'b0), .sum (product[14:2]), .cout (product[15])
    );

    // Every product bit must resolve through all the adder groups.
    always_comb begin
        if (!$isunknown({a, b})) begin
            assert final (!$isunknown(product))
                else $error("array_multiplier: unknown product bits for known operands");
        end
    end

endmodule

// ==== rtl/cla_adder.sv ====
`timescale 1ns/1ps

// Carry-lookahead adder with generate/propagate terms.
// Operand bits come in reversed, so the low-order pair sits at index WIDTH-1.
// The sum comes out in normal order, low-order bit at index 0.
module cla_adder #(
    parameter int WIDTH = 4              // Number of bit pairs.
) (
    input  logic [WIDTH-1:0] in1,       // Low-order bit at the MSB index.
    input  logic [WIDTH-1:0] in2,
    input  logic             cin,       // Tied low where the group has no carry-in.
    output logic [WIDTH-1:0] sum,       // Low-order bit at index 0.
    output logic             cout
);
    logic [WIDTH-1:0] gen;              // Generate per bit pair.
    logic [WIDTH-1:0] prop;             // Propagate per bit pair.
    logic [WIDTH:0]   carry;            // Carry into each bit, plus carry out.

    assign carry[0] = cin;

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        // Pair i is read from the mirrored index.
        assign gen[i]  = in1[WIDTH-1-i] & in2[WIDTH-1-i];
        assign prop[i] = in1[WIDTH-1-i] ^ in2[WIDTH-1-i];

        // Lookahead term for the next bit.
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

// ==== rtl/mac8_pkg.sv ====
package mac8_pkg;

    // Operand and product widths.
    localparam int OP_W   = 8;
    localparam int PROD_W = 2 * OP_W;   // Full 8x8 product.

    // Accumulator, also the width of the result port.
    localparam int ACC_W = 20;

    // Saturation limit, all ones.
    localparam logic [ACC_W-1:0] ACC_MAX = '1;

    // Configuration word layout.
    //   [0]   acc_en    add into the accumulator.
    //   [1]   sat_en    clamp at ACC_MAX on overflow.
    //   [5:2] burst_len items per burst, 0 means no automatic restart.
    localparam int CFG_W = 6;

    localparam int CFG_ACC_BIT = 0;
    localparam int CFG_SAT_BIT = 1;
    localparam int CFG_LEN_LSB = 2;
    localparam int CFG_LEN_W   = 4;     // Also the burst counter width.

endpackage

// ==== rtl/mac8_top.sv ====
`timescale 1ns/1ps

// MAC unit top level, two edges from operands to result.
module mac8_top
    import mac8_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_we,
    input  logic [CFG_W-1:0] cfg_wdata,
    input  logic             acc_clear,
    input  logic             in_valid,
    input  logic [OP_W-1:0]  a,
    input  logic [OP_W-1:0]  b,
    output logic             out_valid,
    output logic [ACC_W-1:0] result,
    output logic             overflow
);
    logic acc_en;           // Mode bits into the datapath.
    logic sat_en;
    logic first_item;       // Restart marker for the current item.

    mac_config cfg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata),
        .acc_clear  (acc_clear),
        .in_valid   (in_valid),
        .acc_en     (acc_en),
        .sat_en     (sat_en),
        .first_item (first_item)
    );

    mac_datapath dp_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .acc_en     (acc_en),
        .sat_en     (sat_en),
        .first_item (first_item),
        .acc_clear  (acc_clear),
        .out_valid  (out_valid),
        .result     (result),
        .overflow   (overflow)
    );

endmodule

// ==== rtl/mac_config.sv ====
`timescale 1ns/1ps

// Mode register and burst counter for the accumulator.
module mac_config
    import mac8_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_we,        // Load cfg_wdata at this edge.
    input  logic [CFG_W-1:0] cfg_wdata,
    input  logic             acc_clear,     // Restarts the burst.
    input  logic             in_valid,      // Accepted item.
    output logic             acc_en,
    output logic             sat_en,
    output logic             first_item     // Level, valid with in_valid.
);
    logic [CFG_W-1:0]     cfg_q;
    logic [CFG_LEN_W-1:0] burst_len;
    logic [CFG_LEN_W-1:0] burst_cnt;    // Items taken in the current burst.

    assign acc_en     = cfg_q[CFG_ACC_BIT];
    assign sat_en     = cfg_q[CFG_SAT_BIT];
    assign burst_len  = cfg_q[CFG_LEN_LSB +: CFG_LEN_W];
    assign first_item = (burst_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q     <= '0;            // Pass-through, wrap, no burst.
            burst_cnt <= '0;
        end else begin
            if (cfg_we) begin
                cfg_q <= cfg_wdata;
            end
            if (acc_clear || cfg_we) begin
                burst_cnt <= '0;        // New settings start a fresh burst.
            end else if (in_valid) begin
                if (burst_len == '0) begin
                    burst_cnt <= CFG_LEN_W'(1);     // Parks at 1, one restart only.
                end else if (burst_cnt == burst_len - 1'b1) begin
                    burst_cnt <= '0;
                end else begin
                    burst_cnt <= burst_cnt + 1'b1;
                end
            end
        end
    end

    // Counter stays inside the burst, including across config writes.
    a_cnt_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        (burst_len != '0) |-> (burst_cnt < burst_len))
        else $error("mac_config: burst counter reached burst_len");

endmodule

// ==== rtl/mac_datapath.sv ====
`timescale 1ns/1ps

// Two-stage MAC datapath.
// Stage one captures operands and mode bits, stage two multiplies and accumulates.
module mac_datapath
    import mac8_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [OP_W-1:0]  a,
    input  logic [OP_W-1:0]  b,
    input  logic             acc_en,        // Mode bits, sampled with the operands.
    input  logic             sat_en,
    input  logic             first_item,
    input  logic             acc_clear,     // Wins over a completing item.
    output logic             out_valid,
    output logic [ACC_W-1:0] result,
    output logic             overflow       // Sticky until clear or reset.
);
    logic [OP_W-1:0]   a_q;
    logic [OP_W-1:0]   b_q;
    logic              vld_q;
    logic              acc_en_q;
    logic              sat_en_q;
    logic              first_q;
    logic [PROD_W-1:0] product;
    logic [ACC_W-1:0]  acc_q;           // Accumulator, drives result directly.
    logic [ACC_W:0]    acc_sum;         // One extra bit for the carry.
    logic              restart;
    logic              carry_out;
    logic [ACC_W-1:0]  acc_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q      <= a;
            b_q      <= b;
            acc_en_q <= acc_en;
            sat_en_q <= sat_en;
            first_q  <= first_item;
        end
    end

    array_multiplier mult_i (.a(a_q), .b(b_q), .product(product));

    assign restart   = !acc_en_q || first_q;    // Product alone.
    assign acc_sum   = {1'b0, acc_q} + {{(ACC_W + 1 - PROD_W){1'b0}}, product};
    assign carry_out = !restart && acc_sum[ACC_W];

    always_comb begin
        if (restart) begin
            acc_next = {{(ACC_W - PROD_W){1'b0}}, product};
        end else if (carry_out && sat_en_q) begin
            acc_next = ACC_MAX;             // Clamp.
        end else begin
            acc_next = acc_sum[ACC_W-1:0];  // Wrap modulo 2^ACC_W.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || acc_clear) begin
            acc_q     <= '0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= vld_q;
            if (vld_q) begin
                acc_q <= acc_next;
            end
            if (vld_q && carry_out) begin
                overflow <= 1'b1;
            end
        end
    end

    assign result = acc_q;

    a_no_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("mac_datapath: out_valid high after reset");

    // Saturating accumulate never drops below the previous sum.
    a_sat_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (vld_q && !acc_clear && sat_en_q && !restart) |=> (result >= $past(result)))
        else $error("mac_datapath: saturating sum wrapped past ACC_MAX");

endmodule

// ==== verif/mac8_tb.sv ====
`timescale 1ns/1ps

// Table-driven testbench for the MAC unit, with a model that tracks the accumulator.
module mac8_tb
    import mac8_pkg::*;
();
    localparam int CLK_PERIOD    = 20;
    localparam int MARGIN_CYCLES = 40;
    localparam int NUM_RANDOM    = 200;

    typedef struct packed {
        logic             cfg;      // Write word into the config register.
        logic [CFG_W-1:0] word;
        logic             clr;      // Pulse acc_clear.
        logic             vld;      // Send an item.
        logic [OP_W-1:0]  a;
        logic [OP_W-1:0]  b;
    } row_t;

    typedef struct packed {
        logic             vld;
        logic [ACC_W-1:0] res;
        logic             ovf;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic             cfg_we;
    logic [CFG_W-1:0] cfg_wdata;
    logic             acc_clear;
    logic             in_valid;
    logic [OP_W-1:0]  a;
    logic [OP_W-1:0]  b;
    logic             out_valid;
    logic [ACC_W-1:0] result;
    logic             overflow;

    row_t    rows [$];              // Stimulus, one row per clock.
    string   row_names [$];
    expect_t expects [$];           // Two entries in flight.
    string   expect_names [$];

    logic [CFG_W-1:0]     m_cfg;    // Model state.
    logic [CFG_LEN_W-1:0] m_cnt;
    logic [ACC_W-1:0]     m_acc;
    logic                 m_ovf;

    integer seed        = 36284;
    bit     table_ready = 1'b0;

    mac8_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic append_row(input string name, input logic cfg, input logic [CFG_W-1:0] word,
                              input logic clr, input logic vld,
                              input logic [OP_W-1:0] op_a, input logic [OP_W-1:0] op_b);
        rows.push_back('{cfg, word, clr, vld, op_a, op_b});
        row_names.push_back(name);
    endtask

    // Idle first, so no item is still completing at the clear edge.
    task automatic insert_clear(input string name);
        append_row(name, 1'b0, '0, 1'b0, 1'b0, 8'd0, 8'd0);
        append_row(name, 1'b0, '0, 1'b1, 1'b0, 8'd0, 8'd0);
    endtask

    task automatic build_table();
        integer r;
        append_row("pt 0x0", 1'b0, '0, 1'b0, 1'b1, 8'd0, 8'd0);     // Config is zero after reset.
        append_row("pt 1x1", 1'b0, '0, 1'b0, 1'b1, 8'd1, 8'd1);
        append_row("pt 255x0", 1'b0, '0, 1'b0, 1'b1, 8'd255, 8'd0);
        append_row("pt 1x255", 1'b0, '0, 1'b0, 1'b1, 8'd1, 8'd255);
        append_row("pt 255x255", 1'b0, '0, 1'b0, 1'b1, 8'd255, 8'd255);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            append_row("pt random", 1'b0, '0, 1'b0, 1'b1, r[7:0], r[15:8]);
        end
        append_row("acc cfg", 1'b1, 6'b000001, 1'b0, 1'b0, 8'd0, 8'd0);
        append_row("acc 3x4", 1'b0, '0, 1'b0, 1'b1, 8'd3, 8'd4);
        append_row("acc 10x20", 1'b0, '0, 1'b0, 1'b1, 8'd10, 8'd20);
        append_row("acc 255x255", 1'b0, '0, 1'b0, 1'b1, 8'd255, 8'd255);
        append_row("acc 200x100", 1'b0, '0, 1'b0, 1'b1, 8'd200, 8'd100);
        insert_clear("acc clear");
        append_row("acc 5x6", 1'b0, '0, 1'b0, 1'b1, 8'd5, 8'd6);
        append_row("acc 7x8", 1'b0, '0, 1'b0, 1'b1, 8'd7, 8'd8);
        append_row("burst cfg", 1'b1, 6'b010001, 1'b0, 1'b0, 8'd0, 8'd0);   // Length 4.
        for (int i = 0; i < 10; i++) begin
            if (i == 6) begin
                insert_clear("burst clear");    // Mid-burst, the count starts over.
            end
            append_row("burst", 1'b0, '0, 1'b0, 1'b1, 8'(i * 7 + 3), 8'(i + 11));
        end
        insert_clear("wrap clear");
        append_row("wrap cfg", 1'b1, 6'b000001, 1'b0, 1'b0, 8'd0, 8'd0);
        for (int i = 0; i < 17; i++) begin
            append_row("wrap 255x255", 1'b0, '0, 1'b0, 1'b1, 8'd255, 8'd255);
        end
        insert_clear("sat clear");
        append_row("sat cfg", 1'b1, 6'b000011, 1'b0, 1'b0, 8'd0, 8'd0);
        for (int i = 0; i < 17; i++) begin
            append_row("sat 255x255", 1'b0, '0, 1'b0, 1'b1, 8'd255, 8'd255);
        end
        append_row("sat hold", 1'b0, '0, 1'b0, 1'b1, 8'd1, 8'd1);         // Stays at the limit.
        insert_clear("gap clear");
        append_row("gap cfg", 1'b1, '0, 1'b0, 1'b0, 8'd0, 8'd0);
        for (int i = 0; i < 12; i++) begin
            append_row("gap", 1'b0, '0, 1'b0, (i % 3) != 1, 8'(i + 12), 8'(i + 12));
        end
        append_row("drain", 1'b0, '0, 1'b0, 1'b0, 8'd0, 8'd0);       // Flush the pipeline.
        append_row("drain", 1'b0, '0, 1'b0, 1'b0, 8'd0, 8'd0);
    endtask

    // Accumulate, wrap, saturate and burst rules applied to one row.
    task automatic model_row(input row_t row, input string name);
        logic [PROD_W-1:0]    prod;
        logic [ACC_W:0]       sum;
        logic [CFG_LEN_W-1:0] len;
        prod = PROD_W'(row.a) * PROD_W'(row.b);
        len  = m_cfg[CFG_LEN_LSB +: CFG_LEN_W];
        if (row.clr) begin
            m_acc = '0;
            m_ovf = 1'b0;
            m_cnt = '0;
        end
        if (row.cfg) begin
            m_cfg = row.word;
            m_cnt = '0;                     // A write starts a new burst.
        end else if (row.vld) begin
            sum = (ACC_W + 1)'(m_acc) + (ACC_W + 1)'(prod);
            if (!m_cfg[CFG_ACC_BIT] || m_cnt == '0) begin
                m_acc = ACC_W'(prod);
            end else if (sum[ACC_W]) begin
                m_ovf = 1'b1;
                m_acc = m_cfg[CFG_SAT_BIT] ? ACC_MAX : sum[ACC_W-1:0];
            end else begin
                m_acc = sum[ACC_W-1:0];
            end
            if (len == '0) begin
                m_cnt = CFG_LEN_W'(1);
            end else if (m_cnt == len - 1'b1) begin
                m_cnt = '0;
            end else begin
                m_cnt = m_cnt + 1'b1;
            end
        end
        expects.push_back('{row.vld, m_acc, m_ovf});
        expect_names.push_back(name);
    endtask

    task automatic check_outputs();
        expect_t exp;
        string   name;
        exp  = expects.pop_front();
        name = expect_names.pop_front();
        compare_value({name, " out_valid"}, 32'(exp.vld), 32'(out_valid));
        if (exp.vld) begin
            compare_value({name, " result"}, 32'(exp.res), 32'(result));
            compare_value({name, " overflow"}, 32'(exp.ovf), 32'(overflow));
        end
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in the expected time");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        acc_clear = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        m_cfg     = '0;
        m_cnt     = '0;
        m_acc     = '0;
        m_ovf     = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_value("reset out_valid", 32'(1'b0), 32'(out_valid));
        compare_value("reset overflow", 32'(1'b0), 32'(overflow));
        for (int i = 0; i < rows.size(); i++) begin
            if (expects.size() == 2) begin
                check_outputs();            // Item from two edges back.
            end
            cfg_we    = rows[i].cfg;
            cfg_wdata = rows[i].word;
            acc_clear = rows[i].clr;
            in_valid  = rows[i].vld;
            a         = rows[i].a;
            b         = rows[i].b;
            model_row(rows[i], row_names[i]);
            @(negedge clk);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule
